//--- build.f
src/sched_cfg_pkg.sv
src/sched_stream_pkg.sv
src/sched_cfg_if.sv
src/sched_regfile.sv
src/x_tile_walker.sv
src/stream_launcher.sv
src/mem_sched_top.sv
testbench/mem_sched_chk.sv
testbench/tb_mem_sched.sv

//--- run_sim.sh
#!/bin/sh
# Compile the scheduler testbench with Verilator, run it and scan the log for failures
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_mem_sched \
  -f build.f \
  -o sim_mem_sched

./obj_dir/sim_mem_sched | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- src/mem_sched_top.sv
// Memory scheduler top level, connects the register file, the X tile walker and the stream launcher
`timescale 1ns/1ps

module mem_sched_top
  import sched_cfg_pkg::*;
  import sched_stream_pkg::*;
#(
  parameter int unsigned ArrayWidth = 12,
  parameter int unsigned TileJmp    = 32
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  // Configuration port
  input  logic      cfg_we_i,
  input  cfg_reg_e  cfg_addr_i,
  input  cfg_word_t cfg_data_i,
  // Scheduler control
  input  logic      x_done_i,
  input  logic      first_load_i,
  input  logic      idle_i,
  // Streamer handshake
  input  logic      x_ready_i,
  input  logic      w_ready_i,
  input  logic      y_ready_i,
  input  logic      z_ready_i,
  output logic      x_req_o,
  output logic      w_req_o,
  output logic      y_req_o,
  output logic      z_req_o,
  // X stream descriptor
  output addr_t     x_base_addr_o,
  output len_t      x_tot_len_o,
  output addr_t     x_d1_stride_o
);

  sched_cfg_if cfg_if ();

  sched_regfile i_regfile (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_we_i   (cfg_we_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_data_i (cfg_data_i),
    .cfg        (cfg_if.regfile)
  );

  x_tile_walker #(
    .ArrayWidth (ArrayWidth),
    .TileJmp    (TileJmp)
  ) i_x_walker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .x_done_i      (x_done_i),
    .cfg           (cfg_if.walker),
    .x_base_addr_o (x_base_addr_o),
    .x_tot_len_o   (x_tot_len_o),
    .x_d1_stride_o (x_d1_stride_o)
  );

  stream_launcher i_launcher (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .x_done_i     (x_done_i),
    .first_load_i (first_load_i),
    .idle_i       (idle_i),
    .cfg          (cfg_if.launcher),
    .x_ready_i    (x_ready_i),
    .w_ready_i    (w_ready_i),
    .y_ready_i    (y_ready_i),
    .z_ready_i    (z_ready_i),
    .x_req_o      (x_req_o),
    .w_req_o      (w_req_o),
    .y_req_o      (y_req_o),
    .z_req_o      (z_req_o)
  );

endmodule : mem_sched_top

//--- src/sched_cfg_if.sv
// Decoded configuration fields passed from the register file to the walker and the launcher
`timescale 1ns/1ps

interface sched_cfg_if import sched_cfg_pkg::*; ();

  cfg_word_t   x_addr;
  iter_t       x_col_iters;
  iter_t       x_row_iters;
  iter_t       w_iters;
  cfg_word_t   x_rows_offs;
  cfg_word_t   x_d1_stride;
  iter_t       tot_x_read;
  logic [7:0]  leftover_rows;
  gemm_op_e    op;

  modport regfile (
    output x_addr, x_col_iters, x_row_iters, w_iters, x_rows_offs,
           x_d1_stride, tot_x_read, leftover_rows, op
  );

  // Tile walk geometry only
  modport walker (
    input x_addr, x_col_iters, x_row_iters, w_iters, x_rows_offs,
          x_d1_stride, leftover_rows
  );

  modport launcher (
    input tot_x_read, op
  );

endinterface : sched_cfg_if

//--- src/sched_cfg_pkg.sv
// Configuration register map and field types shared by the scheduler register file and its users
package sched_cfg_pkg;

  localparam int unsigned NumCfgRegs = 8;

  // Register indices as written over the configuration port
  typedef enum logic [2:0] {
    REG_X_ADDR      = 3'd0,
    // Column iterations in [15:0], row iterations in [31:16]
    REG_X_ITERS     = 3'd1,
    // W passes per row tile in [15:0]
    REG_W_ITERS     = 3'd2,
    REG_X_ROWS_OFFS = 3'd3,
    REG_X_D1_STRIDE = 3'd4,
    // Total X bursts in [15:0]
    REG_TOT_X_READ  = 3'd5,
    // Rows of the last row tile in [31:24], zero for a full tile
    REG_LEFTOVERS   = 3'd6,
    // Operation select in bit 0
    REG_OP_SEL      = 3'd7
  } cfg_reg_e;

  typedef logic [31:0] cfg_word_t;

  typedef logic [15:0] iter_t;

  // Plain product, or product accumulated onto a Y operand
  typedef enum logic {
    OP_GEMM     = 1'b0,
    OP_GEMM_ACC = 1'b1
  } gemm_op_e;

endpackage : sched_cfg_pkg

//--- src/sched_regfile.sv
// Configuration register file, written one word per strobe and decoded into scheduler fields
`timescale 1ns/1ps

module sched_regfile
  import sched_cfg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cfg_we_i,
  input  cfg_reg_e  cfg_addr_i,
  input  cfg_word_t cfg_data_i,
  sched_cfg_if.regfile cfg
);

  cfg_word_t regs_q [NumCfgRegs];

  always_ff @(posedge clk_i or negedge rst_ni) begin : cfg_regs
    if (!rst_ni) begin
      for (int i = 0; i < NumCfgRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (cfg_we_i) begin
      regs_q[cfg_addr_i] <= cfg_data_i;
    end
  end

  // Full words
  assign cfg.x_addr      = regs_q[REG_X_ADDR];
  assign cfg.x_rows_offs = regs_q[REG_X_ROWS_OFFS];
  assign cfg.x_d1_stride = regs_q[REG_X_D1_STRIDE];

  // Packed iteration counts
  assign cfg.x_col_iters = regs_q[REG_X_ITERS][15:0];
  assign cfg.x_row_iters = regs_q[REG_X_ITERS][31:16];
  assign cfg.w_iters     = regs_q[REG_W_ITERS][15:0];
  assign cfg.tot_x_read  = regs_q[REG_TOT_X_READ][15:0];

  // Leftover rows sit in the top byte
  assign cfg.leftover_rows = regs_q[REG_LEFTOVERS][31:24];

  assign cfg.op = gemm_op_e'(regs_q[REG_OP_SEL][0]);

endmodule : sched_regfile

//--- src/sched_stream_pkg.sv
// Streamer-side descriptor types and stream indices used by the walker and the launcher
package sched_stream_pkg;

  localparam int unsigned NumStreams = 4;

  // Byte address in the shared memory
  typedef logic [31:0] addr_t;

  // Burst length counted in rows
  typedef logic [15:0] len_t;

  // Position of each stream in the ready and request vectors
  typedef enum logic [1:0] {
    STR_X = 2'd0,
    STR_W = 2'd1,
    STR_Y = 2'd2,
    STR_Z = 2'd3
  } stream_e;

endpackage : sched_stream_pkg

//--- src/stream_launcher.sv
// Start-request generation for the X, W, Y and Z streamers, with X relaunched until all reads are done
`timescale 1ns/1ps

module stream_launcher
  import sched_cfg_pkg::*;
  import sched_stream_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic x_done_i,
  input  logic first_load_i,
  input  logic idle_i,
  sched_cfg_if.launcher cfg,
  input  logic x_ready_i,
  input  logic w_ready_i,
  input  logic y_ready_i,
  input  logic z_ready_i,
  output logic x_req_o,
  output logic w_req_o,
  output logic y_req_o,
  output logic z_req_o
);

  iter_t                 x_reads_q;
  logic                  x_relaunch;
  logic [NumStreams-1:0] ready;
  logic [NumStreams-1:0] req;

  // Runs free until clear, so the X stream stops once the total is reached
  always_ff @(posedge clk_i or negedge rst_ni) begin : x_read_counter
    if (!rst_ni) begin
      x_reads_q <= '0;
    end else if (clear_i) begin
      x_reads_q <= '0;
    end else if (x_done_i) begin
      x_reads_q <= x_reads_q + iter_t'(1);
    end
  end

  assign x_relaunch = x_reads_q != '0 && x_reads_q != cfg.tot_x_read;

  assign ready[STR_X] = x_ready_i;
  assign ready[STR_W] = w_ready_i;
  assign ready[STR_Y] = y_ready_i;
  assign ready[STR_Z] = z_ready_i;

  always_comb begin : req_start
    req[STR_X] = !idle_i && (first_load_i || x_relaunch) && ready[STR_X];
    req[STR_W] = first_load_i && ready[STR_W];
    // Y only carries the accumulation operand
    req[STR_Y] = first_load_i && cfg.op == OP_GEMM_ACC && ready[STR_Y];
    req[STR_Z] = first_load_i && ready[STR_Z];
  end

  assign x_req_o = req[STR_X];
  assign w_req_o = req[STR_W];
  assign y_req_o = req[STR_Y];
  assign z_req_o = req[STR_Z];

endmodule : stream_launcher

//--- src/x_tile_walker.sv
// X operand tile walker, steps through column tiles, W passes and row tiles on each X burst done
`timescale 1ns/1ps

module x_tile_walker
  import sched_cfg_pkg::*;
  import sched_stream_pkg::*;
#(
  parameter int unsigned ArrayWidth = 12,
  parameter int unsigned TileJmp    = 32
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  x_done_i,
  sched_cfg_if.walker cfg,
  output addr_t x_base_addr_o,
  output len_t  x_tot_len_o,
  output addr_t x_d1_stride_o
);

  iter_t col_cnt_q;
  iter_t w_cnt_q;
  iter_t row_cnt_q;
  addr_t col_offs_q;
  addr_t row_offs_q;

  logic  col_last;
  logic  w_last;
  logic  row_last;
  logic  w_step;
  logic  row_step;

  // Each counter wraps on the last value of its configured range
  assign col_last = col_cnt_q == cfg.x_col_iters - iter_t'(1);
  assign w_last   = w_cnt_q == cfg.w_iters - iter_t'(1);
  assign row_last = row_cnt_q == cfg.x_row_iters - iter_t'(1);

  assign w_step   = x_done_i && col_last;
  assign row_step = w_step && w_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin : col_counter
    if (!rst_ni) begin
      col_cnt_q <= '0;
    end else if (clear_i) begin
      col_cnt_q <= '0;
    end else if (x_done_i) begin
      col_cnt_q <= col_last ? '0 : col_cnt_q + iter_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : w_counter
    if (!rst_ni) begin
      w_cnt_q <= '0;
    end else if (clear_i) begin
      w_cnt_q <= '0;
    end else if (w_step) begin
      w_cnt_q <= w_last ? '0 : w_cnt_q + iter_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : row_counter
    if (!rst_ni) begin
      row_cnt_q <= '0;
    end else if (clear_i) begin
      row_cnt_q <= '0;
    end else if (row_step) begin
      row_cnt_q <= row_last ? '0 : row_cnt_q + iter_t'(1);
    end
  end

  // Column offset restarts at every column wrap, so each W pass rereads the same row tile
  always_ff @(posedge clk_i or negedge rst_ni) begin : col_offset
    if (!rst_ni) begin
      col_offs_q <= '0;
    end else if (clear_i) begin
      col_offs_q <= '0;
    end else if (x_done_i) begin
      col_offs_q <= col_last ? '0 : col_offs_q + addr_t'(TileJmp);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : row_offset
    if (!rst_ni) begin
      row_offs_q <= '0;
    end else if (clear_i) begin
      row_offs_q <= '0;
    end else if (row_step) begin
      row_offs_q <= row_last ? '0 : row_offs_q + cfg.x_rows_offs;
    end
  end

  assign x_base_addr_o = cfg.x_addr + row_offs_q + col_offs_q;

  // Short last row tile when leftovers are configured
  assign x_tot_len_o = (row_last && cfg.leftover_rows != '0) ? len_t'(cfg.leftover_rows)
                                                              : len_t'(ArrayWidth);

  assign x_d1_stride_o = cfg.x_d1_stride;

endmodule : x_tile_walker

//--- testbench/mem_sched_chk.sv
// Concurrent protocol checks bound onto the scheduler top level
`timescale 1ns/1ps

module mem_sched_chk
  import sched_cfg_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input logic     x_ready_i,
  input logic     w_ready_i,
  input logic     y_ready_i,
  input logic     z_ready_i,
  input logic     x_req_o,
  input logic     w_req_o,
  input logic     y_req_o,
  input logic     z_req_o,
  input gemm_op_e op_i
);

  logic any_req;

  assign any_req = x_req_o || w_req_o || y_req_o || z_req_o;

  // A request is only offered to a ready streamer
  req_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!x_req_o || x_ready_i) && (!w_req_o || w_ready_i) &&
    (!y_req_o || y_ready_i) && (!z_req_o || z_ready_i))
    else $error("request raised while its streamer was not ready");

  y_only_acc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    op_i == OP_GEMM |-> !y_req_o)
    else $error("Y request raised under plain GEMM");

  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !any_req)
    else $error("request raised during reset");

endmodule : mem_sched_chk

bind mem_sched_top mem_sched_chk chk (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .x_ready_i (x_ready_i),
  .w_ready_i (w_ready_i),
  .y_ready_i (y_ready_i),
  .z_ready_i (z_ready_i),
  .x_req_o   (x_req_o),
  .w_req_o   (w_req_o),
  .y_req_o   (y_req_o),
  .z_req_o   (z_req_o),
  .op_i      (cfg_if.op)
);

//--- testbench/sched_input.txt
// Records of three hex words: op, a, b
// op 1 writes register a with b, op 2 pulses done and expects base a and length b,
// op 3 expects base a and length b without a done, op 0 ends the list
1 0 00001000
1 1 00020003
1 2 00000002
1 3 00000200
1 4 00000040
1 5 0000000c
1 6 05000000
1 7 00000001
3 00001000 0000000c
2 00001020 0000000c
2 00001040 0000000c
2 00001000 0000000c
2 00001020 0000000c
2 00001040 0000000c
2 00001200 00000005
2 00001220 00000005
2 00001240 00000005
2 00001200 00000005
2 00001220 00000005
2 00001240 00000005
2 00001000 0000000c
0 0 0

//--- testbench/tb_mem_sched.sv
// Testbench for the memory scheduler, runs the walk from the input file and checks the requests
`timescale 1ns/1ps

module tb_mem_sched
  import sched_cfg_pkg::*;
  import sched_stream_pkg::*;
;

  localparam int unsigned ArrayWidth = 12;
  localparam int unsigned TileJmp    = 32;
  localparam int unsigned MaxWords   = 128;
  // Cycles per test: reset, file walk, first load, relaunch, clear
  localparam int unsigned CycleBudget = 4 + 40 + 40 + 30 + 15;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      clear_i;
  logic      cfg_we_i;
  cfg_reg_e  cfg_addr_i;
  cfg_word_t cfg_data_i;
  logic      x_done_i;
  logic      first_load_i;
  logic      idle_i;
  logic      x_ready_i;
  logic      w_ready_i;
  logic      y_ready_i;
  logic      z_ready_i;
  logic      x_req_o;
  logic      w_req_o;
  logic      y_req_o;
  logic      z_req_o;
  addr_t     x_base_addr_o;
  len_t      x_tot_len_o;
  addr_t     x_d1_stride_o;

  logic [31:0] stim [MaxWords];
  logic [31:0] regs_model [8];
  int unsigned m_col;
  int unsigned m_w;
  int unsigned m_row;
  int unsigned m_reads;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  integer      seed;

  mem_sched_top #(
    .ArrayWidth (ArrayWidth),
    .TileJmp    (TileJmp)
  ) UUT (.*);

  always #10 clk_i = ~clk_i;

  initial begin : watchdog
    #(CycleBudget * 2 * 20);
    $display("Timeout, the run did not reach its end in time");
    $display("TESTS FAILED");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) begin
      pass_cnt++;
    end else begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      fail_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("test %s: %s", name, (fail_cnt == fails_before) ? "ok" : "failed");
  endtask

  // Expected values from the walker rule, kept independent of the counters in the design
  function automatic logic [31:0] model_base();
    return regs_model[0] + m_row * regs_model[3] + m_col * TileJmp;
  endfunction

  function automatic logic [31:0] model_len();
    logic [31:0] left;
    left = {24'd0, regs_model[6][31:24]};
    if (m_row == regs_model[1][31:16] - 1 && left != 0) begin
      return left;
    end
    return ArrayWidth;
  endfunction

  function automatic logic model_x_req();
    logic relaunch;
    relaunch = m_reads != 0 && m_reads != regs_model[5][15:0];
    return !idle_i && (first_load_i || relaunch) && x_ready_i;
  endfunction

  task automatic write_cfg(input logic [2:0] addr, input logic [31:0] data);
    cfg_we_i   = 1'b1;
    cfg_addr_i = cfg_reg_e'(addr);
    cfg_data_i = data;
    regs_model[addr] = data;
    @(negedge clk_i);
    cfg_we_i = 1'b0;
  endtask

  task automatic pulse_done();
    x_done_i = 1'b1;
    @(negedge clk_i);
    x_done_i = 1'b0;
    m_reads++;
    if (m_col == regs_model[1][15:0] - 1) begin
      m_col = 0;
      if (m_w == regs_model[2][15:0] - 1) begin
        m_w = 0;
        m_row = (m_row == regs_model[1][31:16] - 1) ? 0 : m_row + 1;
      end else begin
        m_w++;
      end
    end else begin
      m_col++;
    end
  endtask

  task automatic pulse_clear();
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    m_col   = 0;
    m_w     = 0;
    m_row   = 0;
    m_reads = 0;
  endtask

  task automatic check_desc(input logic [31:0] base_exp, input logic [31:0] len_exp);
    check_val("x_base_addr_o", x_base_addr_o, base_exp);
    check_val("x_tot_len_o", 32'(x_tot_len_o), len_exp);
    check_val("x_base_addr_o model", x_base_addr_o, model_base());
    check_val("x_tot_len_o model", 32'(x_tot_len_o), model_len());
  endtask

  task automatic run_file();
    int idx;
    idx = 0;
    while (stim[idx] != 0 && idx + 2 < MaxWords) begin
      case (stim[idx])
        1: write_cfg(stim[idx+1][2:0], stim[idx+2]);
        2: begin
          pulse_done();
          check_desc(stim[idx+1], stim[idx+2]);
        end
        3: check_desc(stim[idx+1], stim[idx+2]);
        default: begin
          $display("Unknown record type %0d in the input file", stim[idx]);
          fail_cnt++;
        end
      endcase
      idx += 3;
    end
  endtask

  task automatic check_reqs();
    #5;
    check_val("x_req_o", 32'(x_req_o), 32'(model_x_req()));
    check_val("w_req_o", 32'(w_req_o), 32'(first_load_i && w_ready_i));
    check_val("y_req_o", 32'(y_req_o),
              32'(first_load_i && y_ready_i && regs_model[7][0]));
    check_val("z_req_o", 32'(z_req_o), 32'(first_load_i && z_ready_i));
  endtask

  initial begin : stimulus
    int fails_before;
    logic [31:0] r;
    seed = 77037;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_addr_i = REG_X_ADDR;
    cfg_data_i = '0;
    x_done_i = 1'b0;
    first_load_i = 1'b0;
    idle_i = 1'b0;
    // All ready flags high but no first load, so nothing may start
    x_ready_i = 1'b1;
    w_ready_i = 1'b1;
    y_ready_i = 1'b1;
    z_ready_i = 1'b1;
    for (int i = 0; i < 8; i++) begin
      regs_model[i] = '0;
    end
    m_col = 0;
    m_w = 0;
    m_row = 0;
    m_reads = 0;
    $readmemh("testbench/sched_input.txt", stim);
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    fails_before = fail_cnt;
    check_reqs();
    check_val("x_base_addr_o", x_base_addr_o, 32'h0);
    @(negedge clk_i);
    report_test("reset", fails_before);

    fails_before = fail_cnt;
    run_file();
    report_test("file walk", fails_before);

    fails_before = fail_cnt;
    first_load_i = 1'b1;
    for (int i = 0; i < 32; i++) begin
      if (i == 16) begin
        write_cfg(3'd7, 32'h0);
      end
      r = $random(seed);
      x_ready_i = r[0];
      w_ready_i = r[1];
      y_ready_i = r[2];
      z_ready_i = r[3];
      check_reqs();
      @(negedge clk_i);
    end
    write_cfg(3'd7, 32'h1);
    first_load_i = 1'b0;
    report_test("first load", fails_before);

    fails_before = fail_cnt;
    pulse_clear();
    x_ready_i = 1'b1;
    check_reqs();
    @(negedge clk_i);
    for (int i = 0; i < 12; i++) begin
      pulse_done();
      check_desc(model_base(), model_len());
      check_reqs();
      @(negedge clk_i);
      if (i == 4) begin
        idle_i = 1'b1;
        check_reqs();
        @(negedge clk_i);
        idle_i = 1'b0;
      end
    end
    report_test("relaunch", fails_before);

    fails_before = fail_cnt;
    for (int i = 0; i < 3; i++) begin
      pulse_done();
    end
    check_reqs();
    @(negedge clk_i);
    pulse_clear();
    check_reqs();
    check_desc(32'h1000, ArrayWidth);
    check_val("x_d1_stride_o", x_d1_stride_o, regs_model[4]);
    report_test("clear", fails_before);

    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_mem_sched
